// ==== design/gauntlet_io_pkg.sv ====
// Gauntlet I/O shared types, loader map boundaries and keyboard scan codes
package gauntlet_io_pkg;

	// ##########################################################
	// Loader address map
	// ##########################################################
	localparam logic [24:0] gfx_end        = 25'h0C0000; // 6 x 128KB video ROM sets
	localparam logic [24:0] prog_base      = 25'h0C0000;
	localparam logic [24:0] prog_hole_a_lo = 25'h0D0000; // Filler after 9A/9B
	localparam logic [24:0] prog_hole_a_hi = 25'h0EFFFF;
	localparam logic [24:0] prog_hole_b_lo = 25'h0F8000; // Filler after 10A/10B
	localparam logic [24:0] prog_hole_b_hi = 25'h0FFFFF;
	localparam logic [24:0] prog_end       = 25'h140000;
	localparam logic [24:0] audio_hi_base  = 25'h140000; // 16S
	localparam logic [24:0] audio_lo_base  = 25'h148000; // 16R
	localparam logic [24:0] chr_base       = 25'h14C000; // 6P
	localparam logic [24:0] rom_end        = 25'h150000;

	localparam logic [7:0] slap_default = 8'd104; // Gauntlet
	localparam logic [7:0] slap_tank    = 8'd118; // Vindicators part II
	localparam int         dip_count    = 8;

	// ##########################################################
	// PS/2 set 2 scan codes
	// ##########################################################
	localparam logic [7:0] key_up    = 8'h75; // Arrows arrive with ext set
	localparam logic [7:0] key_down  = 8'h72;
	localparam logic [7:0] key_left  = 8'h6B;
	localparam logic [7:0] key_right = 8'h74;
	localparam logic [7:0] key_ctrl  = 8'h14;
	localparam logic [7:0] key_alt   = 8'h11;
	localparam logic [7:0] key_a = 8'h1C, key_d = 8'h23, key_e = 8'h24, key_f = 8'h2B;
	localparam logic [7:0] key_g = 8'h34, key_h = 8'h33, key_i = 8'h43, key_j = 8'h3B;
	localparam logic [7:0] key_k = 8'h42, key_l = 8'h4B, key_o = 8'h44, key_q = 8'h15;
	localparam logic [7:0] key_r = 8'h2D, key_s = 8'h1B, key_u = 8'h3C, key_w = 8'h1D;
	localparam logic [7:0] key_y = 8'h35;
	localparam logic [7:0] key_1 = 8'h16, key_2 = 8'h1E; // Start keys
	localparam logic [7:0] key_5 = 8'h2E, key_6 = 8'h36, key_7 = 8'h3D, key_8 = 8'h3E;

	// ##########################################################
	// Enums and bundles
	// ##########################################################
	typedef enum logic [7:0] {
		load_rom  = 8'd0,
		load_slap = 8'd1,  // Protection chip type
		load_dip  = 8'd254
	} load_index_e;

	typedef enum logic [2:0] {
		region_none, region_gfx, region_prog, region_audio_hi, region_audio_lo, region_chr
	} rom_region_e;

	typedef enum logic {scheme_gauntlet, scheme_tank} scheme_e;

	typedef struct packed {
		logic        wr;
		logic        download;
		load_index_e index;
		logic [24:0] addr;
		logic [7:0]  dout;
	} ioctl_bus_t;

	typedef struct packed {
		logic        we;
		rom_region_e region;
		logic [22:0] word_addr;
		logic [31:0] data;
	} rom_write_t;

	typedef struct packed {
		logic       toggle;  // Flips on every new event
		logic       pressed; // Make when set, break when clear
		logic       ext;     // E0 prefix seen
		logic [7:0] code;
	} ps2_key_t;

	typedef struct packed {
		logic [5:0] rsvd;
		logic       start;
		logic       coin;
		logic [3:0] btn;  // Buttons 4..1
		logic [3:0] dir;  // Up down left right
	} joy_t;

	typedef struct packed {
		logic [7:0] p1;
		logic [7:0] p2;
		logic [7:0] p3;
		logic [7:0] p4;
	} player_bits_t;

	typedef struct packed {
		logic service;
		logic coin1;
		logic coin2;
		logic coin3;
		logic coin4;
	} sys_bits_t;

	typedef logic [dip_count-1:0][7:0] dip_bank_t;

endpackage

// ==== design/load_decoder.sv ====
// Loader byte decoder for ROM region strobes, DIP bank and protection type
`timescale 1ns/1ns

module load_decoder (
	input  logic                         clk_sys,
	input  logic                         arst_n,
	input  gauntlet_io_pkg::ioctl_bus_t  ioctl,
	output logic                         rom_we,
	output gauntlet_io_pkg::rom_region_e rom_region,
	output logic [22:0]                  rom_word_addr,
	output logic                         byte_shift,
	output gauntlet_io_pkg::dip_bank_t   dip,
	output logic [7:0]                   slap_type,
	output gauntlet_io_pkg::scheme_e     scheme
);
	import gauntlet_io_pkg::*;

	rom_region_e region_c;
	logic        done_c;    // Last byte of a word seen
	logic [22:0] waddr_c;
	logic        in_hole;
	logic        rom_byte;

	assign rom_byte   = ioctl.wr && ioctl.download && (ioctl.index == load_rom);
	assign byte_shift = rom_byte; // Packer shifts on every counted byte

	assign in_hole = ((ioctl.addr >= prog_hole_a_lo) && (ioctl.addr <= prog_hole_a_hi)) ||
	                 ((ioctl.addr >= prog_hole_b_lo) && (ioctl.addr <= prog_hole_b_hi));

	// ##########################################################
	// Region decode by address
	// ##########################################################
	always_comb begin
		region_c = region_none;
		done_c   = 1'b0;
		waddr_c  = ioctl.addr[22:0]; // Byte regions by default
		if (ioctl.addr < gfx_end) begin
			region_c = region_gfx;
			done_c   = &ioctl.addr[1:0]; // Dword complete on byte 3
			waddr_c  = ioctl.addr[24:2];
		end else if ((ioctl.addr >= prog_base) && (ioctl.addr < prog_end) && !in_hole) begin
			region_c = region_prog;
			done_c   = ioctl.addr[0];    // Word complete on odd byte
			waddr_c  = ioctl.addr[23:1];
		end else if ((ioctl.addr >= audio_hi_base) && (ioctl.addr < audio_lo_base)) begin
			region_c = region_audio_hi;
			done_c   = 1'b1;
		end else if ((ioctl.addr >= audio_lo_base) && (ioctl.addr < chr_base)) begin
			region_c = region_audio_lo;
			done_c   = 1'b1;
		end else if ((ioctl.addr >= chr_base) && (ioctl.addr < rom_end)) begin
			region_c = region_chr;
			done_c   = 1'b1;
		end
	end

	// Strobe, region and settings registers
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rom_we     <= 1'b0;
			rom_region <= region_none;
			dip        <= '0;
			slap_type  <= slap_default;
		end else begin
			rom_we <= rom_byte && done_c; // Single cycle pulse
			if (rom_byte)
				rom_region <= region_c;
			if (ioctl.wr && (ioctl.index == load_dip) && (ioctl.addr < dip_count))
				dip[ioctl.addr[2:0]] <= ioctl.dout;
			if (ioctl.wr && (ioctl.index == load_slap))
				slap_type <= ioctl.dout;
		end
	end

	// Word address follows the byte that completes the word
	always_ff @(posedge clk_sys) begin
		if (rom_byte)
			rom_word_addr <= waddr_c;
	end

	// Vindicators uses tank steering
	assign scheme = (slap_type == slap_tank) ? scheme_tank : scheme_gauntlet;

endmodule

// ==== design/byte_packer.sv ====
// Byte packer that gathers loader bytes into a right-aligned ROM word
`timescale 1ns/1ns

module byte_packer (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        shift,
	input  logic [7:0]  din,
	output logic [31:0] word
);

	// ##########################################################
	// Three byte history
	// ##########################################################
	logic [23:0] acc; // Newest byte in the low lane

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else if (shift) begin
			acc <= {acc[15:0], din}; // Oldest byte drops out the top
		end
	end

	// Dword regions see bytes 1..3 here
	// word and byte regions only use the low lanes
	assign word = {8'h00, acc};

endmodule

// ==== design/key_latch.sv ====
// Keyboard latch that holds player and coin key bits per control scheme
`timescale 1ns/1ns

module key_latch (
	input  logic                          clk_sys,
	input  logic                          arst_n,
	input  gauntlet_io_pkg::ps2_key_t     ps2_key,
	input  gauntlet_io_pkg::scheme_e      scheme,
	output gauntlet_io_pkg::player_bits_t keys,
	output logic [3:0]                    key_coin
);
	import gauntlet_io_pkg::*;

	logic toggle_q; // Previous toggle level
	logic pressed;
	logic event_c;

	assign pressed = ps2_key.pressed;
	assign event_c = (ps2_key.toggle != toggle_q);

	// ##########################################################
	// Held key bits
	// ##########################################################
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			toggle_q <= 1'b0;
			keys     <= '0;
			key_coin <= '0;
		end else begin
			toggle_q <= ps2_key.toggle;
			if (event_c && (scheme == scheme_tank) && !ps2_key.ext) begin
				case (ps2_key.code)
					key_d: keys.p1[7] <= pressed; // Right track back
					key_s: keys.p1[6] <= pressed; // Left track back
					key_e: keys.p1[5] <= pressed; // Right forward
					key_w: keys.p1[4] <= pressed; // Left forward
					key_r: keys.p1[3] <= pressed; // Thumb buttons
					key_q: keys.p1[2] <= pressed;
					key_f: keys.p1[1] <= pressed; // Triggers
					key_a: keys.p1[0] <= pressed;
					key_k: keys.p2[7] <= pressed; // Same layout for P2
					key_j: keys.p2[6] <= pressed;
					key_i: keys.p2[5] <= pressed;
					key_u: keys.p2[4] <= pressed;
					key_o: keys.p2[3] <= pressed;
					key_y: keys.p2[2] <= pressed;
					key_l: keys.p2[1] <= pressed;
					key_h: keys.p2[0] <= pressed;
					key_1: keys.p3[0] <= pressed; // P1 start
					key_2: keys.p3[1] <= pressed; // P2 start
					key_5: key_coin[0] <= pressed;
					key_6: key_coin[1] <= pressed; // Only two coin slots
					default: ;
				endcase
			end else if (event_c && (scheme == scheme_gauntlet)) begin
				case (ps2_key.code)
					// P1 matches with or without E0
					key_up:    keys.p1[7] <= pressed;
					key_down:  keys.p1[6] <= pressed;
					key_left:  keys.p1[5] <= pressed;
					key_right: keys.p1[4] <= pressed;
					key_ctrl:  keys.p1[1] <= pressed; // Fire
					key_alt:   keys.p1[0] <= pressed; // Magic
					default: begin
						if (!ps2_key.ext) begin
							case (ps2_key.code)
								key_r: keys.p2[7] <= pressed;
								key_f: keys.p2[6] <= pressed;
								key_d: keys.p2[5] <= pressed;
								key_g: keys.p2[4] <= pressed;
								key_a: keys.p2[1] <= pressed; // Fire
								key_s: keys.p2[0] <= pressed; // Magic
								key_5: key_coin[0] <= pressed;
								key_6: key_coin[1] <= pressed;
								key_7: key_coin[2] <= pressed;
								key_8: key_coin[3] <= pressed;
								default: ;
							endcase
						end
					end
				endcase
			end
		end
	end

endmodule

// ==== design/player_ports.sv ====
// Player port merge of held keys and joysticks into active-low cabinet inputs
`timescale 1ns/1ns

module player_ports (
	input  logic                          clk_sys,
	input  logic                          arst_n,
	input  gauntlet_io_pkg::scheme_e      scheme,
	input  gauntlet_io_pkg::player_bits_t keys,
	input  logic [3:0]                    key_coin,
	input  gauntlet_io_pkg::joy_t         joy0,
	input  gauntlet_io_pkg::joy_t         joy1,
	input  gauntlet_io_pkg::joy_t         joy2,
	input  gauntlet_io_pkg::joy_t         joy3,
	input  logic                          service,
	output gauntlet_io_pkg::player_bits_t player_in,
	output gauntlet_io_pkg::sys_bits_t    sys_in
);
	import gauntlet_io_pkg::*;

	player_bits_t port_c;
	sys_bits_t    sys_c;

	// Stick to tracks as {right back, left back, right fwd, left fwd}
	function automatic logic [3:0] tank_tracks(input logic [3:0] dir);
		logic [3:0] t;
		case (dir) // Up down left right
			4'b1000: t = 4'b0011; // Both forward
			4'b0100: t = 4'b1100; // Both back
			4'b0010: t = 4'b0110; // Spin left
			4'b0001: t = 4'b1001; // Spin right
			4'b1010: t = 4'b0010;
			4'b1001: t = 4'b0001;
			4'b0110: t = 4'b1000;
			4'b0101: t = 4'b0100;
			default: t = 4'b0000;
		endcase
		return t;
	endfunction

	// ##########################################################
	// Port merge
	// ##########################################################
	always_comb begin
		if (scheme == scheme_tank) begin
			port_c.p1 = ~(keys.p1 | {tank_tracks(joy0.dir), joy0.btn});
			port_c.p2 = ~(keys.p2 | {tank_tracks(joy1.dir), joy1.btn});
			port_c.p3 = ~(keys.p3 | {6'b0, joy1.start, joy0.start}); // Start buttons
			port_c.p4 = ~keys.p4;
		end else begin
			port_c.p1 = ~(keys.p1 | {joy0.dir, joy0.btn});
			port_c.p2 = ~(keys.p2 | {joy1.dir, joy1.btn});
			port_c.p3 = ~(keys.p3 | {joy2.dir, joy2.btn});
			port_c.p4 = ~(keys.p4 | {joy3.dir, joy3.btn});
		end
		sys_c.service = service; // Already active low
		sys_c.coin1   = ~(key_coin[0] | joy0.coin);
		sys_c.coin2   = ~(key_coin[1] | joy1.coin);
		sys_c.coin3   = ~(key_coin[2] | joy2.coin);
		sys_c.coin4   = ~(key_coin[3] | joy3.coin);
	end

	// Output registers idle high
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			player_in <= '1;
			sys_in    <= '1;
		end else begin
			player_in <= port_c;
			sys_in    <= sys_c;
		end
	end

endmodule

// ==== design/gauntlet_io_top.sv ====
// Gauntlet I/O top joining the loader decode and the player input path
`timescale 1ns/1ns

module gauntlet_io_top (
	input  logic                          clk_sys,
	input  logic                          arst_n,
	input  gauntlet_io_pkg::ioctl_bus_t   ioctl,
	input  gauntlet_io_pkg::ps2_key_t     ps2_key,
	input  gauntlet_io_pkg::joy_t         joy0,
	input  gauntlet_io_pkg::joy_t         joy1,
	input  gauntlet_io_pkg::joy_t         joy2,
	input  gauntlet_io_pkg::joy_t         joy3,
	input  logic                          service,
	output gauntlet_io_pkg::rom_write_t   rom_write,
	output gauntlet_io_pkg::dip_bank_t    dip,
	output logic [7:0]                    slap_type,
	output gauntlet_io_pkg::player_bits_t player_in,
	output gauntlet_io_pkg::sys_bits_t    sys_in
);
	import gauntlet_io_pkg::*;

	// ##########################################################
	// Download path
	// ##########################################################
	logic         rom_we;
	rom_region_e  rom_region;
	logic [22:0]  rom_word_addr;
	logic [31:0]  rom_data;
	logic         byte_shift;  // One per counted ROM byte
	scheme_e      scheme;
	player_bits_t keys;
	logic [3:0]   key_coin;

	load_decoder u_load_decoder (
		.clk_sys, .arst_n, .ioctl,
		.rom_we, .rom_region, .rom_word_addr, .byte_shift,
		.dip, .slap_type, .scheme
	);

	byte_packer u_byte_packer (
		.clk_sys, .arst_n, .shift(byte_shift), .din(ioctl.dout), .word(rom_data)
	);

	assign rom_write = '{we: rom_we, region: rom_region, word_addr: rom_word_addr,
	                     data: rom_data};

	// Input path
	key_latch u_key_latch (.clk_sys, .arst_n, .ps2_key, .scheme, .keys, .key_coin);

	player_ports u_player_ports (
		.clk_sys, .arst_n, .scheme, .keys, .key_coin,
		.joy0, .joy1, .joy2, .joy3, .service,
		.player_in, .sys_in
	);

endmodule

// ==== dv/gauntlet_io_sva.sv ====
// Bound checks on the ROM write strobe and the idle state of the player ports
`timescale 1ns/1ns

module gauntlet_io_sva (
	input logic                          clk_sys,
	input logic                          arst_n,
	input gauntlet_io_pkg::rom_write_t   rom_write,
	input gauntlet_io_pkg::player_bits_t player_in,
	input gauntlet_io_pkg::sys_bits_t    sys_in
);
	import gauntlet_io_pkg::*;

	// ##########################################################
	// ROM write strobe
	// ##########################################################
	property we_single_cycle;
		@(posedge clk_sys) disable iff (!arst_n)
		rom_write.we |=> !rom_write.we;
	endproperty

	property we_has_region; // No strobe outside the map
		@(posedge clk_sys) disable iff (!arst_n)
		(rom_write.region == region_none) |-> !rom_write.we;
	endproperty

	// Cabinet inputs idle high while in reset
	property ports_idle_in_reset;
		@(posedge clk_sys)
		!arst_n |-> ((&player_in) && (&sys_in));
	endproperty

	we_single_cycle_a: assert property (we_single_cycle)
		else $error("ROM write strobe stayed high for two cycles");
	we_has_region_a: assert property (we_has_region)
		else $error("ROM write strobe raised with no ROM region");
	ports_idle_in_reset_a: assert property (ports_idle_in_reset)
		else $error("Player or system port active while reset is held");

endmodule

// ==== dv/gauntlet_io_tb.sv ====
// Testbench for the Gauntlet I/O top with model-based concurrent checks
`timescale 1ns/1ns

module gauntlet_io_tb;
	import gauntlet_io_pkg::*;

	// ##########################################################
	// Run length in clock cycles
	// ##########################################################
	localparam int reset_cycles  = 8 + 2;
	localparam int rom_cycles    = 26 * 2 + 8 * 2; // Spaced beats plus burst gaps
	localparam int reject_cycles = 13 * 2 + 2;
	localparam int cfg_cycles    = 9 * 2 + 2 + 5 + 5;
	localparam int gkey_cycles   = 16 * 2 * 4;    // Press and release per key
	localparam int tank_cycles   = 4 + 10 * 3 + 6 + 6 * 4 + 5;
	localparam int joy_cycles    = 4 * 5;
	localparam int stim_cycles   = reset_cycles + rom_cycles + reject_cycles + cfg_cycles +
	                               gkey_cycles + tank_cycles + joy_cycles;
	localparam int timeout_ns    = stim_cycles * 8 * 3 / 2;

	logic         clk_sys;
	logic         arst_n;
	ioctl_bus_t   ioctl;
	ps2_key_t     ps2_key;
	joy_t         joy [4];
	logic         service;
	rom_write_t   rom_write;
	dip_bank_t    dip;
	logic [7:0]   slap_type;
	player_bits_t player_in;
	sys_bits_t    sys_in;

	logic [31:0] lcg_state = 32'h8483_0f8f;
	int          strobes, exp_strobes;     // ROM strobe counts
	int          rom_fails, cfg_fails, port_fails, count_fails;
	int          test_no = 1;
	int          fails_before;

	gauntlet_io_top DUT (
		.clk_sys(clk_sys), .arst_n(arst_n), .ioctl(ioctl), .ps2_key(ps2_key),
		.joy0(joy[0]), .joy1(joy[1]), .joy2(joy[2]), .joy3(joy[3]), .service(service),
		.rom_write(rom_write), .dip(dip), .slap_type(slap_type),
		.player_in(player_in), .sys_in(sys_in)
	);

	bind gauntlet_io_top gauntlet_io_sva sva_checks (
		.clk_sys(clk_sys), .arst_n(arst_n), .rom_write(rom_write),
		.player_in(player_in), .sys_in(sys_in)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys; // 125 MHz
	end

	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24]; // Upper bits are the most random
	endfunction

	// ##########################################################
	// Reference model
	// ##########################################################
	// Bytes per ROM word, zero outside the map
	function automatic int word_bytes(input logic [24:0] a);
		if (a < gfx_end)
			return 4;
		if ((a >= prog_hole_a_lo && a <= prog_hole_a_hi) ||
		    (a >= prog_hole_b_lo && a <= prog_hole_b_hi))
			return 0;
		if (a < prog_end)
			return 2;
		if (a < rom_end)
			return 1;
		return 0;
	endfunction

	function automatic rom_region_e region_of(input logic [24:0] a);
		case (word_bytes(a))
			4: return region_gfx;
			2: return region_prog;
			1: return (a < audio_lo_base) ? region_audio_hi :
			          (a < chr_base) ? region_audio_lo : region_chr;
			default: return region_none;
		endcase
	endfunction

	// Bit slot of a key, 35..32 are coins, -1 when unmapped
	function automatic int key_slot(input logic [7:0] slap, input logic ext,
			input logic [7:0] c);
		if (slap != slap_tank) begin
			case (c)
				key_up:    return 31; // Arrows match with or without E0
				key_down:  return 30;
				key_left:  return 29;
				key_right: return 28;
				key_ctrl:  return 25;
				key_alt:   return 24;
				default: ;
			endcase
			if (ext)
				return -1;
			case (c)
				key_r: return 23;
				key_f: return 22;
				key_d: return 21;
				key_g: return 20;
				key_a: return 17;
				key_s: return 16;
				key_5: return 32;
				key_6: return 33;
				key_7: return 34;
				key_8: return 35;
				default: return -1;
			endcase
		end
		if (ext)
			return -1;
		case (c) // Tank layout
			key_d: return 31;
			key_s: return 30;
			key_e: return 29;
			key_w: return 28;
			key_r: return 27;
			key_q: return 26;
			key_f: return 25;
			key_a: return 24;
			key_k: return 23;
			key_j: return 22;
			key_i: return 21;
			key_u: return 20;
			key_o: return 19;
			key_y: return 18;
			key_l: return 17;
			key_h: return 16;
			key_1: return 8;
			key_2: return 9;
			key_5: return 32;
			key_6: return 33;
			default: return -1;
		endcase
	endfunction

	// Track bits {right back, left back, right fwd, left fwd}
	function automatic logic [3:0] tracks(input logic [3:0] dir);
		case (dir) // Up, down, left, right
			4'b1000: return 4'b0011;
			4'b0100: return 4'b1100;
			4'b0010: return 4'b0110;
			4'b0001: return 4'b1001;
			4'b1010: return 4'b0010;
			4'b1001: return 4'b0001;
			4'b0110: return 4'b1000;
			4'b0101: return 4'b0100;
			default: return 4'b0000;
		endcase
	endfunction

	function automatic player_bits_t ports_expected(input logic [7:0] slap,
			input logic [31:0] k, input joy_t j0, input joy_t j1, input joy_t j2,
			input joy_t j3);
		player_bits_t p;
		if (slap == slap_tank) begin
			p.p1 = {tracks(j0.dir), j0.btn};
			p.p2 = {tracks(j1.dir), j1.btn};
			p.p3 = {6'b0, j1.start, j0.start};
			p.p4 = 8'h00; // Keys only
		end else begin
			p.p1 = {j0.dir, j0.btn};
			p.p2 = {j1.dir, j1.btn};
			p.p3 = {j2.dir, j2.btn};
			p.p4 = {j3.dir, j3.btn};
		end
		return ~(p | k);
	endfunction

	function automatic sys_bits_t sys_expected(input logic svc, input logic [3:0] kc,
			input joy_t j0, input joy_t j1, input joy_t j2, input joy_t j3);
		return {svc, ~(kc[0] | j0.coin), ~(kc[1] | j1.coin), ~(kc[2] | j2.coin),
		        ~(kc[3] | j3.coin)};
	endfunction

	logic         m_we;
	rom_region_e  m_region;
	logic [22:0]  m_waddr;
	logic [23:0]  m_hist;   // Last three counted bytes
	dip_bank_t    m_dip;
	logic [7:0]   m_slap;
	logic [35:0]  m_keys;   // Coins over player key bits
	logic         m_toggle;
	player_bits_t m_player;
	sys_bits_t    m_sys;

	always @(posedge clk_sys or negedge arst_n) begin
		int   wb;
		int   slot;
		logic counted;
		if (!arst_n) begin
			m_we     <= 1'b0;
			m_region <= region_none;
			m_waddr  <= '0;
			m_hist   <= '0;
			m_dip    <= '0;
			m_slap   <= slap_default;
			m_keys   <= '0;
			m_toggle <= 1'b0;
			m_player <= '1;
			m_sys    <= '1;
		end else begin
			wb      = word_bytes(ioctl.addr);
			counted = ioctl.wr && ioctl.download && (ioctl.index == load_rom);
			if (counted) begin
				m_hist   <= {m_hist[15:0], ioctl.dout};
				m_region <= region_of(ioctl.addr);
				m_waddr  <= (wb == 0) ? ioctl.addr : ioctl.addr / wb;
			end
			m_we <= counted && ((wb == 4 && ioctl.addr[1:0] == 2'd3) ||
			                    (wb == 2 && ioctl.addr[0]) || wb == 1);
			if (ioctl.wr && ioctl.index == load_dip && ioctl.addr < 8)
				m_dip[ioctl.addr] <= ioctl.dout;
			if (ioctl.wr && ioctl.index == load_slap)
				m_slap <= ioctl.dout;
			m_toggle <= ps2_key.toggle;
			slot = key_slot(m_slap, ps2_key.ext, ps2_key.code);
			if (ps2_key.toggle != m_toggle && slot >= 0)
				m_keys[slot] <= ps2_key.pressed;
			m_player <= ports_expected(m_slap, m_keys[31:0], joy[0], joy[1], joy[2], joy[3]);
			m_sys    <= sys_expected(service, m_keys[35:32], joy[0], joy[1], joy[2], joy[3]);
		end
	end

	always @(negedge clk_sys) begin
		if (arst_n && rom_write.we)
			strobes++;
	end

	// ##########################################################
	// Checks against the model
	// ##########################################################
	check_rom: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(rom_write.we == m_we) && (!m_we || (rom_write.region == m_region &&
		 rom_write.word_addr == m_waddr && rom_write.data == {8'h00, m_hist})))
		else begin
			rom_fails++;
			$display("Error at %0t ns: ROM write we=%0b region=%0d addr=%h data=%h", $time,
				$sampled(rom_write.we), $sampled(rom_write.region),
				$sampled(rom_write.word_addr), $sampled(rom_write.data));
		end

	check_cfg: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(dip == m_dip) && (slap_type == m_slap))
		else begin
			cfg_fails++;
			$display("Error at %0t ns: dip=%h slap=%0d, expected dip=%h slap=%0d", $time,
				$sampled(dip), $sampled(slap_type), $sampled(m_dip), $sampled(m_slap));
		end

	check_ports: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(player_in == m_player) && (sys_in == m_sys))
		else begin
			port_fails++;
			$display("Error at %0t ns: ports %h/%h, expected %h/%h", $time,
				$sampled(player_in), $sampled(sys_in), $sampled(m_player), $sampled(m_sys));
		end

	// ##########################################################
	// Stimulus
	// ##########################################################
	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			ioctl.wr <= 1'b0;
		end
	endtask

	// One loader write followed by a quiet cycle
	task automatic beat(input load_index_e idx, input logic [24:0] a, input logic [7:0] d,
			input logic dl);
		@(posedge clk_sys);
		ioctl <= '{wr: 1'b1, download: dl, index: idx, addr: a, dout: d};
		idle(1);
	endtask

	task automatic rom_burst(input logic [24:0] start, input int n, input int width);
		for (int i = 0; i < n; i++)
			beat(load_rom, start + 25'(i), rand_byte(), 1'b1);
		idle(2);
		exp_strobes += n / width;
	endtask

	task automatic key_event(input logic [7:0] code, input logic ext, input logic down);
		@(posedge clk_sys);
		ps2_key <= '{toggle: !ps2_key.toggle, pressed: down, ext: ext, code: code};
		idle(3);
	endtask

	task automatic check_strobes();
		assert (strobes == exp_strobes) else begin
			count_fails++;
			$display("Error at %0t ns: saw %0d ROM strobes, expected %0d", $time,
				strobes, exp_strobes);
		end
	endtask

	task automatic report_test(input string name);
		int now_fails;
		now_fails = rom_fails + cfg_fails + port_fails + count_fails;
		$display("Test %0d %s finished, %0d failed checks", test_no, name,
			now_fails - fails_before);
		test_no++;
		fails_before = now_fails;
	endtask

	initial begin
		logic [7:0]  codes [16];
		logic [3:0]  dirs [10];
		logic [15:0] r;
		int          total;
		codes = '{key_up, key_down, key_left, key_right, key_ctrl, key_alt, key_r, key_f,
		          key_d, key_g, key_a, key_s, key_5, key_6, key_7, key_8};
		dirs  = '{4'b1000, 4'b0100, 4'b0010, 4'b0001, 4'b1010, 4'b1001, 4'b0110, 4'b0101,
		          4'b1100, 4'b0011}; // Last two map to nothing
		ioctl   = '0;
		ps2_key = '0;
		joy     = '{default: '0};
		service = 1'b1;
		arst_n  = 1'b1;
		#1 arst_n = 1'b0;
		repeat (8) @(posedge clk_sys);
		arst_n <= 1'b1;
		idle(2);

		rom_burst(25'h000000, 8, 4); // gfx
		rom_burst(25'h0BFFFC, 4, 4);
		rom_burst(prog_base, 4, 2);
		rom_burst(25'h0F0000, 2, 2); // Between the holes
		rom_burst(prog_end - 25'd2, 2, 2);
		rom_burst(audio_lo_base - 25'd2, 2, 1);
		rom_burst(audio_lo_base, 2, 1);
		rom_burst(rom_end - 25'd2, 2, 1);
		check_strobes();
		report_test("ROM regions");

		beat(load_rom, prog_hole_a_lo, rand_byte(), 1'b1);
		beat(load_rom, prog_hole_a_lo + 25'd1, rand_byte(), 1'b1);
		beat(load_rom, prog_hole_a_hi, rand_byte(), 1'b1);
		beat(load_rom, prog_hole_b_lo, rand_byte(), 1'b1);
		beat(load_rom, prog_hole_b_hi, rand_byte(), 1'b1);
		beat(load_rom, rom_end, rand_byte(), 1'b1);
		beat(load_rom, rom_end + 25'd1, rand_byte(), 1'b1);
		beat(load_rom, 25'h1FFFFFF, rand_byte(), 1'b1);
		for (int a = 16; a < 20; a++)
			beat(load_rom, 25'(a), rand_byte(), 1'b0); // Download low
		beat(load_slap, 25'd3, slap_default, 1'b1);
		idle(2);
		check_strobes();
		report_test("ROM rejects");

		for (int a = 0; a <= dip_count; a++)
			beat(load_dip, 25'(a), rand_byte(), 1'b0); // Address 8 is ignored
		idle(2);
		joy[0].dir <= 4'b1000;
		beat(load_slap, 25'd0, slap_tank, 1'b0);
		idle(3);
		beat(load_slap, 25'd0, slap_default, 1'b0);
		idle(3);
		joy[0].dir <= 4'b0000;
		report_test("DIP and protection type");

		for (int i = 0; i < 16; i++) begin
			key_event(codes[i], i < 4, 1'b1);
			key_event(codes[i], i < 4, 1'b0);
		end
		report_test("Gauntlet keys");

		beat(load_slap, 25'd0, slap_tank, 1'b0);
		idle(2);
		for (int i = 0; i < 10; i++) begin
			@(posedge clk_sys);
			joy[0].dir <= dirs[i];
			joy[1].dir <= dirs[(i + 3) % 10];
			idle(2);
		end
		@(posedge clk_sys);
		joy[0].dir   <= 4'b0000;
		joy[1].dir   <= 4'b0000;
		joy[0].start <= 1'b1;
		joy[1].start <= 1'b1;
		idle(2);
		@(posedge clk_sys);
		joy[0].start <= 1'b0;
		joy[1].start <= 1'b0;
		idle(2);
		key_event(key_7, 1'b0, 1'b1); // No coin slot in tank mode
		key_event(key_8, 1'b0, 1'b1);
		key_event(key_7, 1'b0, 1'b0);
		key_event(key_8, 1'b0, 1'b0);
		key_event(key_1, 1'b0, 1'b1);
		key_event(key_1, 1'b0, 1'b0);
		beat(load_slap, 25'd0, slap_default, 1'b0);
		idle(3);
		report_test("Tank steering");

		for (int n = 0; n < 4; n++) begin
			r = {rand_byte(), rand_byte()};
			@(posedge clk_sys);
			joy[n]  <= joy_t'({6'b0, r[9:0]});
			service <= r[10];
			idle(2);
			@(posedge clk_sys);
			joy[n]  <= '0;
			service <= 1'b1;
			idle(1);
		end
		report_test("Gauntlet joysticks");

		total = rom_fails + cfg_fails + port_fails + count_fails;
		$display("Failed checks: rom %0d, config %0d, ports %0d, counts %0d, total %0d",
			rom_fails, cfg_fails, port_fails, count_fails, total);
		if (total == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Watchdog at one and a half times the stimulus length
	initial begin
		#(timeout_ns);
		$display("Timeout: the tests did not finish within %0d ns", timeout_ns);
		$display("Errors found");
		$finish;
	end

endmodule

// ==== compile.f ====
design/gauntlet_io_pkg.sv
design/load_decoder.sv
design/byte_packer.sv
design/key_latch.sv
design/player_ports.sv
design/gauntlet_io_top.sv
dv/gauntlet_io_sva.sv
dv/gauntlet_io_tb.sv

// ==== Bender.yml ====
package:
  name: gauntlet_io

sources:
  - files:
      - design/gauntlet_io_pkg.sv
      - design/load_decoder.sv
      - design/byte_packer.sv
      - design/key_latch.sv
      - design/player_ports.sv
      - design/gauntlet_io_top.sv
  - target: test
    files:
      - dv/gauntlet_io_sva.sv
      - dv/gauntlet_io_tb.sv
